// ==== layer_mux_net.f ====
+incdir+verilog
verilog/nn_pkg.sv
verilog/weight_store.sv
verilog/neuron.sv
verilog/neuron_layer.sv
verilog/output_aggregator.sv
verilog/input_aggregator.sv
verilog/layer_mux_net.sv
verification/layer_mux_net_tb.sv

// ==== Bender.yml ====
package:
  name: layer_mux_net

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/nn_pkg.sv
      - verilog/weight_store.sv
      - verilog/neuron.sv
      - verilog/neuron_layer.sv
      - verilog/output_aggregator.sv
      - verilog/input_aggregator.sv
      - verilog/layer_mux_net.sv
  - target: test
    files:
      - verification/layer_mux_net_tb.sv

// ==== verification/layer_mux_net_tb.sv ====
//////////////////////////////////////////////////////////////////////
// testbench for the layer-muxed network, fixed, extreme and random
// vectors against a reference model, checked by assertions
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "nn_consts.svh"

module layer_mux_net_tb;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 5;
    localparam int NUM_RANDOM   = 16;
    // ones, two extremes, the ignored start case, then the random runs
    localparam int NUM_RUNS     = 4 + NUM_RANDOM;
    localparam int RUN_CYCLES   = 200;
    localparam int ACT_MAX      = (1 << (`NN_ACT_W - 1)) - 1;

    logic             clk;
    logic             rst;
    logic             start;
    nn_pkg::act_vec_t start_input;
    nn_pkg::act_vec_t final_output;
    logic             final_output_valid;

    // model result for the last accepted start
    nn_pkg::act_vec_t expected;
    // high from an accepted start until its final output shows up
    logic             busy;
    logic             started;
    int               seed;

    layer_mux_net UUT (
        .clk                (clk),
        .rst                (rst),
        .start              (start),
        .start_input        (start_input),
        .final_output       (final_output),
        .final_output_valid (final_output_valid)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////
    function automatic int weight_of(int l, int n, int i);
        return ((7 * l + 3 * n + 5 * i) % 9) - 4;
    endfunction

    // all logical layers, shift then relu then clamp
    function automatic nn_pkg::act_vec_t model_network(nn_pkg::act_vec_t x);
        nn_pkg::act_vec_t                          cur;
        nn_pkg::act_vec_t                          nxt;
        logic [`NN_LAYER_MAX*`NN_NUM_NEURON-1:0] masks;
        int                                        sum;
        int                                        a;
        masks = `NN_LAYER_MASKS;
        cur   = x;
        for (int l = 0; l < `NN_LAYER_MAX; l++) begin
            for (int n = 0; n < `NN_NUM_NEURON; n++) begin
                sum = 0;
                for (int i = 0; i < `NN_NUM_NEURON; i++) begin
                    a   = cur[i];
                    sum = sum + a * weight_of(l, n, i);
                end
                sum = sum >>> `NN_FRAC_BITS;
                // inactive neurons read as zero in the next layer
                if (!masks[l * `NN_NUM_NEURON + n] || sum < 0) begin
                    sum = 0;
                end else if (sum > ACT_MAX) begin
                    sum = ACT_MAX;
                end
                nxt[n] = nn_pkg::act_t'(sum);
            end
            cur = nxt;
        end
        return cur;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // failure reporting
    //////////////////////////////////////////////////////////////////////
    task automatic fail_run(input string what);
        $display("%s", what);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string msg);
        fail_run($sformatf("Mismatch at %0t: %s", $time, msg));
    endtask

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////
    // quiet outputs until the first start
    a_idle_after_reset: assert property (@(posedge clk) disable iff (rst)
        !started |-> !final_output_valid && final_output == '0)
        else report_mismatch($sformatf("output %h valid %b before any start",
                                       final_output, final_output_valid));

    a_final_value: assert property (@(posedge clk) disable iff (rst)
        $rose(final_output_valid) |-> final_output == expected)
        else report_mismatch($sformatf("final_output %h, model gives %h",
                                       final_output, expected));

    // last layer mask 0011, neurons 2 and 3 are off
    a_inactive_zero: assert property (@(posedge clk) disable iff (rst)
        final_output_valid |-> final_output[2] == '0 && final_output[3] == '0)
        else report_mismatch($sformatf("inactive neuron nonzero in %h", final_output));

    a_final_stable: assert property (@(posedge clk) disable iff (rst)
        $past(final_output_valid) && final_output_valid |-> $stable(final_output))
        else report_mismatch("final_output changed while valid");

    // valid only drops for an accepted start
    a_valid_held: assert property (@(posedge clk) disable iff (rst)
        $fell(final_output_valid) |-> busy)
        else report_mismatch("final_output_valid fell without an accepted start");

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////
    // called on a falling edge, one-cycle start
    task automatic pulse_start(input nn_pkg::act_vec_t v);
        start_input = v;
        start       = 1'b1;
        @(negedge clk);
        start       = 1'b0;
    endtask

    task automatic launch_run(input nn_pkg::act_vec_t v);
        @(negedge clk);
        expected = model_network(v);
        busy     = 1'b1;
        started  = 1'b1;
        pulse_start(v);
    endtask

    // old valid drops first, then wait for the new one
    task automatic wait_final();
        int cycles;
        cycles = 0;
        while (final_output_valid && cycles < RUN_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (final_output_valid) begin
            fail_run("final_output_valid stayed high after an accepted start");
        end
        while (!final_output_valid && cycles < RUN_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (!final_output_valid) begin
            fail_run("final_output_valid never rose after an accepted start");
        end
        busy = 1'b0;
    endtask

    initial begin
        nn_pkg::act_vec_t vec_a;
        nn_pkg::act_vec_t vec_b;
        seed        = 90;
        rst         = 1'b1;
        start       = 1'b0;
        start_input = '0;
        expected    = '0;
        busy        = 1'b0;
        started     = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        // some idle cycles with outputs at zero
        repeat (4) @(negedge clk);

        launch_run({`NN_NUM_NEURON{8'sd1}});
        wait_final();

        // saturation and relu corners
        launch_run({`NN_NUM_NEURON{8'sh7f}});
        wait_final();
        launch_run({`NN_NUM_NEURON{8'sh80}});
        wait_final();

        // second start mid-run must be dropped
        vec_a = $random(seed);
        vec_b = $random(seed);
        launch_run(vec_a);
        repeat (3) @(negedge clk);
        pulse_start(vec_b);
        wait_final();
        // valid holds while idle
        repeat (6) @(negedge clk);

        for (int r = 0; r < NUM_RANDOM; r++) begin
            vec_a = $random(seed);
            launch_run(vec_a);
            wait_final();
        end

        repeat (4) @(negedge clk);
        $display("*** PASSED ***");
        $finish;
    end

    // watchdog sized for every run at its longest
    initial begin
        #(NUM_RUNS * RUN_CYCLES * CLK_PERIOD);
        fail_run($sformatf("run timed out after %0d ns without finishing",
                           NUM_RUNS * RUN_CYCLES * CLK_PERIOD));
    end

endmodule

// ==== verilog/layer_mux_net.sv ====
//////////////////////////////////////////////////////////////////////
// top of the layer-multiplexed network, start in, final vector out
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module layer_mux_net (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  nn_pkg::act_vec_t start_input,
    output nn_pkg::act_vec_t final_output,
    output logic             final_output_valid
);

    nn_pkg::act_vec_t     out_inputs;
    nn_pkg::layer_cmd_t   cmd;
    logic                 layer_start;
    nn_pkg::act_vec_t     results;
    nn_pkg::neuron_mask_t done;
    nn_pkg::act_vec_t     layer_input;
    nn_pkg::neuron_mask_t layer_input_valid;

    // sequencer
    input_aggregator u_input_aggregator (
        .clk                (clk),
        .rst                (rst),
        .start              (start),
        .start_input        (start_input),
        .layer_input        (layer_input),
        .layer_input_valid  (layer_input_valid),
        .out_inputs         (out_inputs),
        .cmd                (cmd),
        .layer_start        (layer_start),
        .final_output       (final_output),
        .final_output_valid (final_output_valid)
    );

    // shared physical layer
    neuron_layer u_neuron_layer (
        .clk         (clk),
        .rst         (rst),
        .layer_start (layer_start),
        .inputs      (out_inputs),
        .cmd         (cmd),
        .results     (results),
        .done        (done)
    );

    // results loop back to the sequencer
    output_aggregator u_output_aggregator (
        .clk               (clk),
        .rst               (rst),
        .layer_start       (layer_start),
        .results           (results),
        .done              (done),
        .layer_input       (layer_input),
        .layer_input_valid (layer_input_valid)
    );

endmodule

// ==== verilog/input_aggregator.sv ====
//////////////////////////////////////////////////////////////////////
// layer sequencer, feeds each logical layer its input and command and
// presents the last layer's activations with a valid level
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "nn_consts.svh"

module input_aggregator (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  nn_pkg::act_vec_t     start_input,
    input  nn_pkg::act_vec_t     layer_input,
    input  nn_pkg::neuron_mask_t layer_input_valid,
    output nn_pkg::act_vec_t     out_inputs,
    output nn_pkg::layer_cmd_t   cmd,
    output logic                 layer_start,
    output nn_pkg::act_vec_t     final_output,
    output logic                 final_output_valid
);

    typedef enum logic [1:0] {
        IDLE,
        START,
        WAIT
    } state_t;

    localparam logic [`NN_LAYER_MAX*`NN_NUM_NEURON-1:0] LAYER_MASKS = `NN_LAYER_MASKS;
    localparam nn_pkg::layer_idx_t LAST_LAYER = nn_pkg::layer_idx_t'(`NN_LAYER_MAX - 1);

    state_t               state;
    nn_pkg::layer_idx_t   layer;
    nn_pkg::neuron_mask_t layer_mask;
    logic                 layer_done;

    // mask of the layer about to be issued
    assign layer_mask = LAYER_MASKS[layer*`NN_NUM_NEURON +: `NN_NUM_NEURON];

    // valid bits clear on the edge that ends the layer_start cycle,
    // so ignore that one cycle of stale valids
    assign layer_done = !layer_start
                        && ((layer_input_valid & cmd.active) == cmd.active);

    //////////////////////////////////////////////////////////////////////
    // sequencer
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state              <= IDLE;
            layer              <= '0;
            layer_start        <= 1'b0;
            final_output       <= '0;
            final_output_valid <= 1'b0;
        end else begin
            // strobe lasts a single cycle
            layer_start <= 1'b0;
            case (state)
                IDLE: begin
                    layer <= '0;
                    if (start) begin
                        state <= START;
                    end
                end
                START: begin
                    // layer 0 takes the outside vector
                    out_inputs         <= (layer == '0) ? start_input : layer_input;
                    cmd.layer          <= layer;
                    cmd.active         <= layer_mask;
                    layer_start        <= 1'b1;
                    final_output       <= '0;
                    final_output_valid <= 1'b0;
                    state              <= WAIT;
                end
                WAIT: begin
                    if (layer_done) begin
                        if (layer == LAST_LAYER) begin
                            final_output       <= layer_input;
                            final_output_valid <= 1'b1;
                            layer              <= '0;
                            state              <= IDLE;
                        end else begin
                            // results loop back as the next input
                            layer <= layer + 1'b1;
                            state <= START;
                        end
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////
    // neuron layer relies on a clean single-cycle start
    a_start_single: assert property (@(posedge clk) disable iff (rst)
        layer_start |=> !layer_start);

    a_layer_range: assert property (@(posedge clk) disable iff (rst)
        layer < `NN_LAYER_MAX);

endmodule

// ==== verilog/output_aggregator.sv ====
//////////////////////////////////////////////////////////////////////
// collects per-neuron results and valid bits for the next layer input
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "nn_consts.svh"

module output_aggregator (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 layer_start,
    input  nn_pkg::act_vec_t     results,
    input  nn_pkg::neuron_mask_t done,
    output nn_pkg::act_vec_t     layer_input,
    output nn_pkg::neuron_mask_t layer_input_valid
);

    // held result and valid per neuron
    // inactive neurons stay zero through the layer
    always_ff @(posedge clk) begin
        if (rst) begin
            layer_input       <= '0;
            layer_input_valid <= '0;
        end else if (layer_start) begin
            // new layer, drop everything from the last one
            layer_input       <= '0;
            layer_input_valid <= '0;
        end else begin
            for (int n = 0; n < `NN_NUM_NEURON; n++) begin
                if (done[n]) begin
                    layer_input[n]       <= results[n];
                    layer_input_valid[n] <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== verilog/neuron_layer.sv ====
//////////////////////////////////////////////////////////////////////
// physical neuron layer, latches one logical layer and steps all
// neurons through the input vector in lockstep
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "nn_consts.svh"

module neuron_layer (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 layer_start,
    input  nn_pkg::act_vec_t     inputs,
    input  nn_pkg::layer_cmd_t   cmd,
    output nn_pkg::act_vec_t     results,
    output nn_pkg::neuron_mask_t done
);

    localparam nn_pkg::input_idx_t LAST_IDX = nn_pkg::input_idx_t'(`NN_NUM_NEURON - 1);

    nn_pkg::act_vec_t    in_reg;
    nn_pkg::layer_cmd_t  cmd_reg;
    nn_pkg::input_idx_t  idx;
    nn_pkg::act_t        cur_act;
    nn_pkg::weight_vec_t weights;
    logic                run;
    logic                fin;

    // latch the layer, then one mac per input, then one finish cycle
    always_ff @(posedge clk) begin
        if (layer_start) begin
            in_reg  <= inputs;
            cmd_reg <= cmd;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            run <= 1'b0;
            fin <= 1'b0;
            idx <= '0;
        end else begin
            fin <= 1'b0;
            if (layer_start) begin
                run <= 1'b1;
                idx <= '0;
            end else if (run) begin
                idx <= idx + 1'b1;
                if (idx == LAST_IDX) begin
                    run <= 1'b0;
                    fin <= 1'b1;
                end
            end
        end
    end

    // same input activation goes to every neuron
    assign cur_act = in_reg[idx];

    weight_store u_weight_store (
        .layer     (cmd_reg.layer),
        .input_idx (idx),
        .weights   (weights)
    );

    for (genvar g = 0; g < `NN_NUM_NEURON; g++) begin : g_neuron
        neuron u_neuron (
            .clk    (clk),
            .rst    (rst),
            .active (cmd_reg.active[g]),
            .clear  (layer_start),
            .acc_en (run),
            .finish (fin),
            .in_act (cur_act),
            .weight (weights[g]),
            .result (results[g]),
            .done   (done[g])
        );
    end

    // sequencer must wait for the previous layer to finish
    a_no_overlap: assert property (@(posedge clk) disable iff (rst)
        layer_start |-> !run && !fin);

endmodule

// ==== verilog/neuron.sv ====
//////////////////////////////////////////////////////////////////////
// single neuron, mac over the input vector then shift, relu, saturate
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "nn_consts.svh"

module neuron (
    input  logic            clk,
    input  logic            rst,
    input  logic            active,
    input  logic            clear,
    input  logic            acc_en,
    input  logic            finish,
    input  nn_pkg::act_t    in_act,
    input  nn_pkg::weight_t weight,
    output nn_pkg::act_t    result,
    output logic            done
);

    localparam nn_pkg::acc_t ACT_MAX = nn_pkg::acc_t'((1 << (`NN_ACT_W - 1)) - 1);

    nn_pkg::acc_t               acc;
    nn_pkg::acc_t               prod;
    nn_pkg::acc_t               shifted;
    logic signed [`NN_ACC_W:0]  sum_ext;

    // both operands signed, sign extends to accumulator width
    assign prod    = in_act * weight;
    // one extra bit to see overflow
    assign sum_ext = acc + prod;
    assign shifted = acc >>> `NN_FRAC_BITS;

    always_ff @(posedge clk) begin
        if (clear) begin
            acc <= '0;
        end else if (acc_en) begin
            acc <= sum_ext[`NN_ACC_W-1:0];
        end
    end

    // relu then clamp to the top of act_t
    always_ff @(posedge clk) begin
        if (finish) begin
            if (!active || shifted < 0) begin
                result <= '0;
            end else if (shifted > ACT_MAX) begin
                result <= ACT_MAX[`NN_ACT_W-1:0];
            end else begin
                result <= shifted[`NN_ACT_W-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            done <= 1'b0;
        end else begin
            done <= finish && active;
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        acc_en |-> sum_ext[`NN_ACC_W] == sum_ext[`NN_ACC_W-1]);

endmodule

// ==== verilog/weight_store.sv ====
//////////////////////////////////////////////////////////////////////
// fixed weight table, one weight per neuron for a layer and an input
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "nn_consts.svh"

module weight_store (
    input  nn_pkg::layer_idx_t  layer,
    input  nn_pkg::input_idx_t  input_idx,
    output nn_pkg::weight_vec_t weights
);

    localparam int ROW_W    = `NN_NUM_NEURON * `NN_WEIGHT_W;
    localparam int NUM_ROWS = `NN_LAYER_MAX * `NN_NUM_NEURON;

    // w(l, n, i) = ((7l + 3n + 5i) mod 9) - 4, rows ordered layer then input
    function automatic logic [NUM_ROWS*ROW_W-1:0] build_table();
        logic [NUM_ROWS*ROW_W-1:0] t;
        int                        row;
        t = '0;
        for (int l = 0; l < `NN_LAYER_MAX; l++) begin
            for (int i = 0; i < `NN_NUM_NEURON; i++) begin
                row = l * `NN_NUM_NEURON + i;
                for (int n = 0; n < `NN_NUM_NEURON; n++) begin
                    t[row*ROW_W + n*`NN_WEIGHT_W +: `NN_WEIGHT_W] =
                        nn_pkg::weight_t'(((7*l + 3*n + 5*i) % 9) - 4);
                end
            end
        end
        return t;
    endfunction

    localparam logic [NUM_ROWS*ROW_W-1:0] TABLE = build_table();

    int sel;

    always_comb begin
        sel = int'(layer) * `NN_NUM_NEURON + int'(input_idx);
        // layer index 3 has no row
        if (layer < `NN_LAYER_MAX) begin
            weights = TABLE[sel*ROW_W +: ROW_W];
        end else begin
            weights = '0;
        end
    end

endmodule

// ==== verilog/nn_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// datapath types shared by the network blocks and the testbench
//////////////////////////////////////////////////////////////////////
`include "nn_consts.svh"

package nn_pkg;

    // one activation and a full vector, neuron 0 in the low bits
    typedef logic signed [`NN_ACT_W-1:0] act_t;
    typedef act_t [`NN_NUM_NEURON-1:0] act_vec_t;

    // one weight per neuron for a given layer and input
    typedef logic signed [`NN_WEIGHT_W-1:0] weight_t;
    typedef weight_t [`NN_NUM_NEURON-1:0] weight_vec_t;

    // mac accumulator
    typedef logic signed [`NN_ACC_W-1:0] acc_t;

    // indices
    typedef logic [1:0] layer_idx_t;
    typedef logic [1:0] input_idx_t;

    // one bit per physical neuron
    typedef logic [`NN_NUM_NEURON-1:0] neuron_mask_t;

    // what the neuron layer runs for one logical layer
    typedef struct packed {
        layer_idx_t   layer;
        neuron_mask_t active;
    } layer_cmd_t;

endpackage

// ==== verilog/nn_consts.svh ====
//////////////////////////////////////////////////////////////////////
// sizes, layer masks and fixed-point shift of the layer-muxed network
// include wherever one of the NN_ constants is needed
//////////////////////////////////////////////////////////////////////
`ifndef NN_CONSTS_SVH
`define NN_CONSTS_SVH

// physical neurons, also the input vector length
`define NN_NUM_NEURON 4

// signed datapath widths
`define NN_ACT_W 8
`define NN_WEIGHT_W 4
`define NN_ACC_W 16

// logical layers run on the one physical layer
`define NN_LAYER_MAX 3

// arithmetic right shift applied to the sum before relu
`define NN_FRAC_BITS 2

// active neurons per layer, layer 0 in the low nibble, neuron 0 at bit 0
`define NN_LAYER_MASKS 12'b0011_0111_1111

`endif
